/* source/ifetch_pkg.sv */
package ifetch_pkg;

    // address and data widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // byte address split: [1:0] zero, [5:2] index, [17:6] tag
    localparam int INDEX_W = 4;
    localparam int LINES   = 16;
    localparam int TAG_LSB = 6;
    localparam int TAG_W   = 12;

    // first fetch address out of reset
    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

    // fetch queue geometry
    localparam int FQ_DEPTH = 4;
    localparam int FQ_CNT_W = 3;

    // cache control states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1,
        REFILL = 2'd2
    } cache_state_t;

endpackage

/* source/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic                           clk,
    input  logic                           rst,

    // request side from the PC unit
    input  logic [ifetch_pkg::ADDR_W-1:0]  req_addr,
    input  logic                           req_valid,
    output logic [ifetch_pkg::DATA_W-1:0]  resp_data,
    output logic                           resp_ready,

    // refill port to external memory
    output logic [ifetch_pkg::ADDR_W-1:0]  mem_addr,
    output logic                           mem_valid,
    input  logic [ifetch_pkg::DATA_W-1:0]  mem_data,
    input  logic                           mem_ready
);

    import ifetch_pkg::*;

    cache_state_t state;
    cache_state_t next_state;

    // one word per line
    logic [DATA_W-1:0] data_arr [LINES];
    logic [TAG_W-1:0]  tag_arr  [LINES];
    logic [LINES-1:0]  valid_q;

    logic [ADDR_W-1:0]  addr_q;
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic               hit;

    assign idx = addr_q[TAG_LSB-1 -: INDEX_W];
    assign tag = addr_q[TAG_LSB +: TAG_W];

    // bits above the tag are ignored
    assign hit = valid_q[idx] && (tag_arr[idx] == tag);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (req_valid)
                begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP:
            begin
                if (hit)
                begin
                    next_state = IDLE;
                end
                else
                begin
                    next_state = REFILL;
                end
            end
            REFILL:
            begin
                // retry the lookup once the line is written
                if (mem_ready)
                begin
                    next_state = LOOKUP;
                end
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    // capture the request address on entry to lookup
    always_ff @(posedge clk)
    begin
        if (state == IDLE && req_valid)
        begin
            addr_q <= req_addr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else if (state == REFILL && mem_ready)
        begin
            valid_q[idx] <= 1'b1;
        end
    end

    // refill replaces whatever line held this index
    always_ff @(posedge clk)
    begin
        if (state == REFILL && mem_ready)
        begin
            data_arr[idx] <= mem_data;
            tag_arr[idx]  <= tag;
        end
    end

    assign resp_ready = (state == LOOKUP) && hit;
    assign resp_data  = data_arr[idx];

    assign mem_valid = (state == REFILL);
    assign mem_addr  = {addr_q[ADDR_W-1:2], 2'b00};

endmodule

/* source/fetch_pc.sv */
`timescale 1ns/1ps

module fetch_pc (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            redirect,
    input  logic [ifetch_pkg::ADDR_W-1:0]   redirect_pc,
    input  logic [ifetch_pkg::FQ_CNT_W-1:0] count,
    output logic [ifetch_pkg::ADDR_W-1:0]   req_addr,
    output logic                            req_valid,
    input  logic [ifetch_pkg::DATA_W-1:0]   resp_data,
    input  logic                            resp_ready,
    output logic                            push,
    output logic [ifetch_pkg::ADDR_W-1:0]   push_pc,
    output logic [ifetch_pkg::DATA_W-1:0]   push_instr
);

    import ifetch_pkg::*;

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] addr_q;
    logic              in_flight;
    logic              discard;
    logic              issue;

    // a single request at a time, and only with room in the queue
    assign issue = !in_flight && (count < FQ_CNT_W'(FQ_DEPTH));

    assign req_valid = in_flight || issue;
    assign req_addr  = in_flight ? addr_q : pc;

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            addr_q <= pc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc        <= RESET_PC;
            in_flight <= 1'b0;
            discard   <= 1'b0;
        end
        else
        begin
            if (issue)
            begin
                in_flight <= 1'b1;
            end
            else if (resp_ready)
            begin
                in_flight <= 1'b0;
            end

            // response still owed for the old path
            if (redirect && req_valid && !resp_ready)
            begin
                discard <= 1'b1;
            end
            else if (resp_ready)
            begin
                discard <= 1'b0;
            end

            if (redirect)
            begin
                pc <= redirect_pc;
            end
            else if (resp_ready && !discard)
            begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign push       = resp_ready && !discard;
    assign push_pc    = addr_q;
    assign push_instr = resp_data;

endmodule

/* source/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,
    input  logic                            push,
    input  logic [ifetch_pkg::ADDR_W-1:0]   push_pc,
    input  logic [ifetch_pkg::DATA_W-1:0]   push_instr,
    input  logic                            pop,
    output logic [ifetch_pkg::FQ_CNT_W-1:0] count,
    output logic                            instr_valid,
    output logic [ifetch_pkg::ADDR_W-1:0]   instr_pc,
    output logic [ifetch_pkg::DATA_W-1:0]   instr
);

    import ifetch_pkg::*;

    logic [ADDR_W-1:0] pc_mem    [FQ_DEPTH];
    logic [DATA_W-1:0] instr_mem [FQ_DEPTH];

    // depth is a power of two, pointers wrap on their own
    logic [$clog2(FQ_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FQ_DEPTH)-1:0] rd_ptr;
    logic                        do_pop;

    // pop on an empty queue is dropped
    assign do_pop = pop && instr_valid;

    always_ff @(posedge clk)
    begin
        if (push && !flush)
        begin
            pc_mem[wr_ptr]    <= push_pc;
            instr_mem[wr_ptr] <= push_instr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // head entry
    assign instr_valid = (count != '0);
    assign instr_pc    = pc_mem[rd_ptr];
    assign instr       = instr_mem[rd_ptr];

endmodule

/* source/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                           clk,
    input  logic                           rst,

    // core side
    input  logic                           redirect,
    input  logic [ifetch_pkg::ADDR_W-1:0]  redirect_pc,
    input  logic                           instr_pop,
    output logic                           instr_valid,
    output logic [ifetch_pkg::ADDR_W-1:0]  instr_pc,
    output logic [ifetch_pkg::DATA_W-1:0]  instr,

    // memory side
    output logic [ifetch_pkg::ADDR_W-1:0]  mem_addr,
    output logic                           mem_valid,
    input  logic [ifetch_pkg::DATA_W-1:0]  mem_data,
    input  logic                           mem_ready
);

    import ifetch_pkg::*;

    logic [ADDR_W-1:0]   req_addr;
    logic                req_valid;
    logic [DATA_W-1:0]   resp_data;
    logic                resp_ready;
    logic                push;
    logic [ADDR_W-1:0]   push_pc;
    logic [DATA_W-1:0]   push_instr;
    logic [FQ_CNT_W-1:0] count;

    fetch_pc u_fetch_pc (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .count       (count),
        .req_addr    (req_addr),
        .req_valid   (req_valid),
        .resp_data   (resp_data),
        .resp_ready  (resp_ready),
        .push        (push),
        .push_pc     (push_pc),
        .push_instr  (push_instr)
    );

    icache u_icache (
        .clk        (clk),
        .rst        (rst),
        .req_addr   (req_addr),
        .req_valid  (req_valid),
        .resp_data  (resp_data),
        .resp_ready (resp_ready),
        .mem_addr   (mem_addr),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data),
        .mem_ready  (mem_ready)
    );

    // a redirect also drops everything already queued
    fetch_queue u_fetch_queue (
        .clk         (clk),
        .rst         (rst),
        .flush       (redirect),
        .push        (push),
        .push_pc     (push_pc),
        .push_instr  (push_instr),
        .pop         (instr_pop),
        .count       (count),
        .instr_valid (instr_valid),
        .instr_pc    (instr_pc),
        .instr       (instr)
    );

endmodule

/* sim/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mem_addr,
    input  logic        mem_valid,
    output logic [31:0] mem_data,
    output logic        mem_ready,
    output int          req_count
);

    // 4 KB of code, higher address bits alias
    logic [31:0] words [1024];
    logic [31:0] lfsr;
    logic [31:0] req_a;
    int          delay;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        lfsr_bit = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    endfunction

    initial
    begin
        int          fd;
        string       line;
        byte         kind;
        logic [31:0] addr;
        logic [31:0] value;
        for (int i = 0; i < 1024; i++)
        begin
            words[i] = (i + 1) * 32'h9e37_79b9;
        end
        fd = $fopen("sim/fetch_stim.txt", "r");
        if (fd == 0)
        begin
            $display("mem_model could not open sim/fetch_stim.txt");
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if ($sscanf(line, "%c %h %h", kind, addr, value) == 3)
                begin
                    if (kind == "M")
                    begin
                        words[addr[11:2]] = value;
                    end
                end
            end
            $fclose(fd);
        end
    end

    initial
    begin
        mem_ready = 1'b0;
        mem_data  = '0;
        req_count = 0;
        lfsr      = 32'haafc;
        forever
        begin
            @(posedge clk);
            #2;
            mem_ready = 1'b0;
            if (!rst && mem_valid)
            begin
                req_count++;
                req_a = mem_addr;
                // two lfsr bits give 1 to 4 cycles
                delay = 1 + {lfsr_bit(), lfsr_bit()};
                repeat (delay) @(posedge clk);
                #2;
                mem_data  = words[req_a[11:2]];
                mem_ready = 1'b1;
            end
        end
    end

endmodule

/* sim/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

    import ifetch_pkg::*;

    logic              clk;
    logic              rst;
    logic              redirect;
    logic [ADDR_W-1:0] redirect_pc;
    logic              instr_pop;
    logic              instr_valid;
    logic [ADDR_W-1:0] instr_pc;
    logic [DATA_W-1:0] instr;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_valid;
    logic [DATA_W-1:0] mem_data;
    logic              mem_ready;
    int                req_count;

    byte               cmd_q [$];
    logic [31:0]       arg_q [$];
    bit                loaded;

    // reference model state
    logic [ADDR_W-1:0] model_pc;
    logic [ADDR_W-1:0] frontier;
    logic [TAG_W-1:0]  shadow_tag [LINES];
    logic [LINES-1:0]  shadow_valid;
    logic [ADDR_W-1:0] miss_q [$];
    logic [ADDR_W-1:0] mem_log [$];
    int                expect_reqs;
    int                pass_cnt;
    int                fail_cnt;
    int                test_errs;

    fetch_top DUT (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_pop   (instr_pop),
        .instr_valid (instr_valid),
        .instr_pc    (instr_pc),
        .instr       (instr),
        .mem_addr    (mem_addr),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .mem_ready   (mem_ready)
    );

    mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_data  (mem_data),
        .mem_ready (mem_ready),
        .req_count (req_count)
    );

    always #20 clk = ~clk;

    // refill addresses in the order memory answered them
    always @(posedge clk)
    begin
        if (mem_ready)
        begin
            mem_log.push_back(mem_addr);
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        begin
            pass_cnt++;
        end
        else
        begin
            fail_cnt++;
            test_errs++;
            $display("FAILED t=%0t %s expected %h got %h", $time, what, expected, actual);
        end
    endtask

    task automatic load_script();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] value;
        fd = $fopen("sim/fetch_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file sim/fetch_stim.txt");
            fail_cnt++;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                n = $sscanf(line, "%c", kind);
                if (kind == "R")
                begin
                    n = $sscanf(line, "%c %h", kind, value);
                end
                else
                begin
                    n = $sscanf(line, "%c %d", kind, value);
                end
                if (n == 2 && (kind == "P" || kind == "W" || kind == "R"))
                begin
                    cmd_q.push_back(kind);
                    arg_q.push_back(value);
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    // shadow tags predict which fetches miss
    task automatic track_fetch(input logic [ADDR_W-1:0] addr);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        idx = addr[TAG_LSB-1 -: INDEX_W];
        tag = addr[TAG_LSB +: TAG_W];
        if (!shadow_valid[idx] || shadow_tag[idx] != tag)
        begin
            expect_reqs++;
            miss_q.push_back(addr);
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx]   = tag;
        end
    endtask

    task automatic pop_instr();
        while (!instr_valid)
        begin
            @(posedge clk);
            #2;
        end
        check_value("instr_pc", model_pc, instr_pc);
        check_value("instr", u_mem.words[model_pc[11:2]], instr);
        instr_pop = 1'b1;
        @(posedge clk);
        #2;
        instr_pop = 1'b0;
        model_pc  = model_pc + 4;
    endtask

    // after a long wait the queue is full and nothing is in flight
    task automatic idle_cycles(input int n);
        logic [ADDR_W-1:0] got;
        repeat (n) @(posedge clk);
        #2;
        while (frontier < model_pc + 4 * FQ_DEPTH)
        begin
            track_fetch(frontier);
            frontier = frontier + 4;
        end
        check_value("req_count", expect_reqs, req_count);
        while (miss_q.size() > 0)
        begin
            if (mem_log.size() > 0)
            begin
                got = mem_log.pop_front();
            end
            else
            begin
                got = 'x;
            end
            check_value("mem_addr", miss_q.pop_front(), got);
        end
    endtask

    task automatic send_redirect(input logic [ADDR_W-1:0] addr);
        redirect    = 1'b1;
        redirect_pc = addr;
        @(posedge clk);
        #2;
        redirect = 1'b0;
        model_pc = addr;
        frontier = addr;
    endtask

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        redirect     = 1'b0;
        redirect_pc  = '0;
        instr_pop    = 1'b0;
        model_pc     = RESET_PC;
        frontier     = RESET_PC;
        shadow_valid = '0;
        expect_reqs  = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        test_errs    = 0;
        load_script();
        repeat (4)
        begin
            @(posedge clk);
            #2;
            check_value("instr_valid", 0, instr_valid);
            check_value("mem_valid", 0, mem_valid);
        end
        rst = 1'b0;
        @(posedge clk);
        #2;
        check_value("instr_valid", 0, instr_valid);
        check_value("mem_valid", 0, mem_valid);
        $display("test 0 reset: %0d errors", test_errs);
        for (int i = 0; i < cmd_q.size(); i++)
        begin
            test_errs = 0;
            case (cmd_q[i])
                "P": repeat (arg_q[i]) pop_instr();
                "W": idle_cycles(arg_q[i]);
                "R":
                begin
                    // right after a pop the next fetch is in flight and gets dropped
                    if (i > 0 && cmd_q[i-1] == "P")
                    begin
                        track_fetch(frontier);
                    end
                    send_redirect(arg_q[i]);
                end
                default: ;
            endcase
            if (cmd_q[i] == "R")
            begin
                $display("test %0d R %h: %0d errors", i + 1, arg_q[i], test_errs);
            end
            else
            begin
                $display("test %0d %c %0d: %0d errors", i + 1, cmd_q[i], arg_q[i], test_errs);
            end
        end
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial
    begin
        int limit;
        wait (loaded);
        limit = 200;
        foreach (cmd_q[i])
        begin
            limit += (cmd_q[i] == "R") ? 12 : (arg_q[i] + 1) * 12;
        end
        repeat (limit) @(posedge clk);
        $display("run timed out after %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* sim/fetch_stim.txt */
# M address word : memory word in hex, all other words use the fill pattern
# P n : pop n instructions, W n : wait n cycles, R address : redirect in hex
M 00000000 00000013
M 00000100 fe010113
M 00000140 00112e23
M 00000200 00000517
W 50
P 20
W 50
R 00000020
W 50
P 8
W 50
R 00000100
W 50
P 4
W 50
R 00000140
W 50
P 1
R 00000100
W 50
P 1
R 00000200
W 60
P 6
W 50

/* project.f */
source/ifetch_pkg.sv
source/icache.sv
source/fetch_pc.sv
source/fetch_queue.sv
source/fetch_top.sv
sim/mem_model.sv
sim/tb_fetch_top.sv

/* Bender.yml */
package:
  name: ifetch

dependencies: {}

sources:
  - files:
      - source/ifetch_pkg.sv
      - source/icache.sv
      - source/fetch_pc.sv
      - source/fetch_queue.sv
      - source/fetch_top.sv

  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/tb_fetch_top.sv
